// ==== design/dcache_mshr.sv ====
module dcache_mshr #(
	parameter int TAG_W       = dcache_pkg::DEF_TAG_W,
	parameter int IDX_W       = dcache_pkg::DEF_IDX_W,
	parameter int MSHR_NUM    = dcache_pkg::DEF_MSHR_NUM,
	parameter int MEM_CREDITS = dcache_pkg::DEF_MEM_CREDITS,
	localparam int MSHR_IDX_W = $clog2(MSHR_NUM)
) (
	input  logic                    clk,
	input  logic                    rst,

	// miss from the cache pipeline
	input  logic                    miss_i,
	input  logic [TAG_W-1:0]        miss_tag_i,
	input  logic [IDX_W-1:0]        miss_idx_i,
	input  dcache_pkg::message_t    miss_msg_i,

	// memory side
	output logic                    mem_req_o,
	output logic [TAG_W-1:0]        mem_req_tag_o,
	output logic [IDX_W-1:0]        mem_req_idx_o,
	output dcache_pkg::message_t    mem_req_msg_o,
	input  logic                    mem_rsp_i,

	// fill back to the cache
	output logic                    fill_o,
	output logic [TAG_W-1:0]        fill_tag_o,
	output logic [IDX_W-1:0]        fill_idx_o,
	output dcache_pkg::message_t    fill_msg_o,
	output logic [MSHR_IDX_W-1:0]   fill_iss_slot_o,

	// load and store queue lookups
	input  logic [TAG_W-1:0]        lq_tag_i,
	input  logic [IDX_W-1:0]        lq_idx_i,
	input  logic [TAG_W-1:0]        sq_tag_i,
	input  logic [IDX_W-1:0]        sq_idx_i,
	output logic                    lq_hit_o,
	output logic                    lq_fwd_o,
	output logic                    sq_hit_o,

	output logic                    mshr_full_o
);

	logic                   alloc;
	logic [MSHR_IDX_W-1:0]  alloc_slot;
	logic                   rsp_full;

	// a fill happens in the same cycle as the memory response
	assign fill_o      = mem_rsp_i;
	assign mshr_full_o = rsp_full;

	// --------------------
	// issue side
	// --------------------
	mshr_iss #(
		.TAG_W       (TAG_W),
		.IDX_W       (IDX_W),
		.MSHR_NUM    (MSHR_NUM),
		.MEM_CREDITS (MEM_CREDITS)
	) iss_i (
		.clk           (clk),
		.rst           (rst),
		.miss_i        (miss_i),
		.miss_tag_i    (miss_tag_i),
		.miss_idx_i    (miss_idx_i),
		.miss_msg_i    (miss_msg_i),
		.rsp_full_i    (rsp_full),
		.mem_rsp_i     (mem_rsp_i),
		.alloc_o       (alloc),
		.alloc_slot_o  (alloc_slot),
		.mem_req_o     (mem_req_o),
		.mem_req_tag_o (mem_req_tag_o),
		.mem_req_idx_o (mem_req_idx_o),
		.mem_req_msg_o (mem_req_msg_o)
	);

	// --------------------
	// response side
	// --------------------
	mshr_rsp #(
		.TAG_W    (TAG_W),
		.IDX_W    (IDX_W),
		.MSHR_NUM (MSHR_NUM)
	) rsp_i (
		.clk          (clk),
		.rst          (rst),
		.lq_tag_i     (lq_tag_i),
		.lq_idx_i     (lq_idx_i),
		.sq_tag_i     (sq_tag_i),
		.sq_idx_i     (sq_idx_i),
		.alloc_i      (alloc),
		.alloc_tag_i  (miss_tag_i),
		.alloc_idx_i  (miss_idx_i),
		.alloc_msg_i  (miss_msg_i),
		.alloc_slot_i (alloc_slot),
		.ack_i        (mem_rsp_i),
		.rsp_tag_o    (fill_tag_o),
		.rsp_idx_o    (fill_idx_o),
		.rsp_msg_o    (fill_msg_o),
		.rsp_slot_o   (fill_iss_slot_o),
		.lq_hit_o     (lq_hit_o),
		.lq_fwd_o     (lq_fwd_o),
		.sq_hit_o     (sq_hit_o),
		.full_o       (rsp_full)
	);

endmodule : dcache_mshr

// ==== design/dcache_pkg.sv ====
package dcache_pkg;

	// --------------------
	// memory transaction kinds
	// --------------------

	// MSG_NONE marks an entry that holds no miss
	typedef enum logic [1:0] {
		MSG_NONE    = 2'b00,
		MSG_READ    = 2'b01,
		MSG_WRITE   = 2'b10,
		MSG_UPGRADE = 2'b11
	} message_t;

	// --------------------
	// default sizes
	// --------------------

	// line address split
	localparam int DEF_TAG_W = 20;
	localparam int DEF_IDX_W = 6;

	// must be a power of two
	localparam int DEF_MSHR_NUM = 4;

	// requests allowed in flight to memory
	localparam int DEF_MEM_CREDITS = 2;

endpackage : dcache_pkg

// ==== design/mshr_iss.sv ====
module mshr_iss #(
	parameter int TAG_W       = dcache_pkg::DEF_TAG_W,
	parameter int IDX_W       = dcache_pkg::DEF_IDX_W,
	parameter int MSHR_NUM    = dcache_pkg::DEF_MSHR_NUM,
	parameter int MEM_CREDITS = dcache_pkg::DEF_MEM_CREDITS,
	localparam int MSHR_IDX_W = $clog2(MSHR_NUM),
	localparam int CRD_W      = $clog2(MEM_CREDITS + 1)
) (
	input  logic                    clk,
	input  logic                    rst,

	input  logic                    miss_i,
	input  logic [TAG_W-1:0]        miss_tag_i,
	input  logic [IDX_W-1:0]        miss_idx_i,
	input  dcache_pkg::message_t    miss_msg_i,
	input  logic                    rsp_full_i,
	input  logic                    mem_rsp_i,

	output logic                    alloc_o,
	output logic [MSHR_IDX_W-1:0]   alloc_slot_o,
	output logic                    mem_req_o,
	output logic [TAG_W-1:0]        mem_req_tag_o,
	output logic [IDX_W-1:0]        mem_req_idx_o,
	output dcache_pkg::message_t    mem_req_msg_o
);

	// entries waiting to be sent to memory
	logic [TAG_W-1:0]      tag_q [MSHR_NUM];
	logic [IDX_W-1:0]      idx_q [MSHR_NUM];
	dcache_pkg::message_t  msg_q [MSHR_NUM];

	// pointers carry the wrap bit in their msb
	logic [MSHR_IDX_W:0]   head_q;
	logic [MSHR_IDX_W:0]   tail_q;
	logic [CRD_W-1:0]      credits_q;

	logic                  buf_empty;
	logic                  buf_full;
	logic                  issue;

	// --------------------
	// allocate
	// --------------------
	assign buf_empty = (head_q == tail_q);
	assign buf_full  = (head_q[MSHR_IDX_W-1:0] == tail_q[MSHR_IDX_W-1:0]) &&
			   (head_q[MSHR_IDX_W] != tail_q[MSHR_IDX_W]);

	// the response queue is never smaller than this buffer, so its full flag is enough
	assign alloc_o      = miss_i & ~rsp_full_i;
	assign alloc_slot_o = tail_q[MSHR_IDX_W-1:0];

	always_ff @(posedge clk) begin
		if (alloc_o) begin
			tag_q[tail_q[MSHR_IDX_W-1:0]] <= miss_tag_i;
			idx_q[tail_q[MSHR_IDX_W-1:0]] <= miss_idx_i;
			msg_q[tail_q[MSHR_IDX_W-1:0]] <= miss_msg_i;
		end
	end

	// --------------------
	// issue under credits
	// --------------------

	// a credit coming back this cycle can be spent right away
	assign issue = ~buf_empty & ((credits_q != '0) | mem_rsp_i);

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q    <= '0;
			tail_q    <= '0;
			credits_q <= CRD_W'(MEM_CREDITS);
			mem_req_o <= 1'b0;
		end else begin
			if (alloc_o)
				tail_q <= tail_q + 1'b1;
			if (issue)
				head_q <= head_q + 1'b1;
			mem_req_o <= issue;
			credits_q <= credits_q - CRD_W'(issue) + CRD_W'(mem_rsp_i);
		end
	end

	// request fields hold until the next issue
	always_ff @(posedge clk) begin
		if (issue) begin
			mem_req_tag_o <= tag_q[head_q[MSHR_IDX_W-1:0]];
			mem_req_idx_o <= idx_q[head_q[MSHR_IDX_W-1:0]];
			mem_req_msg_o <= msg_q[head_q[MSHR_IDX_W-1:0]];
		end
	end

	// --------------------
	// checks
	// --------------------
	a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
		alloc_o |-> !buf_full)
		else $error("mshr_iss accepted a miss while its buffer was full");

	// a response with nothing in flight pushes the count past its limit
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits_q <= CRD_W'(MEM_CREDITS))
		else $error("mshr_iss credit count above limit");

endmodule : mshr_iss

// ==== design/mshr_rsp.sv ====
module mshr_rsp #(
	parameter int TAG_W       = dcache_pkg::DEF_TAG_W,
	parameter int IDX_W       = dcache_pkg::DEF_IDX_W,
	parameter int MSHR_NUM    = dcache_pkg::DEF_MSHR_NUM,
	localparam int MSHR_IDX_W = $clog2(MSHR_NUM)
) (
	input  logic                    clk,
	input  logic                    rst,

	input  logic [TAG_W-1:0]        lq_tag_i,
	input  logic [IDX_W-1:0]        lq_idx_i,
	input  logic [TAG_W-1:0]        sq_tag_i,
	input  logic [IDX_W-1:0]        sq_idx_i,

	input  logic                    alloc_i,
	input  logic [TAG_W-1:0]        alloc_tag_i,
	input  logic [IDX_W-1:0]        alloc_idx_i,
	input  dcache_pkg::message_t    alloc_msg_i,
	input  logic [MSHR_IDX_W-1:0]   alloc_slot_i,

	input  logic                    ack_i,
	output logic [TAG_W-1:0]        rsp_tag_o,
	output logic [IDX_W-1:0]        rsp_idx_o,
	output dcache_pkg::message_t    rsp_msg_o,
	output logic [MSHR_IDX_W-1:0]   rsp_slot_o,

	output logic                    lq_hit_o,
	output logic                    lq_fwd_o,
	output logic                    sq_hit_o,
	output logic                    full_o
);

	logic [MSHR_NUM-1:0]    vld_q;
	logic [TAG_W-1:0]       tag_q [MSHR_NUM];
	logic [IDX_W-1:0]       idx_q [MSHR_NUM];
	dcache_pkg::message_t   msg_q [MSHR_NUM];
	logic [MSHR_IDX_W-1:0]  slot_q [MSHR_NUM];

	// tail allocates, head releases; msb is the wrap bit
	logic [MSHR_IDX_W:0]    head_q;
	logic [MSHR_IDX_W:0]    tail_q;
	logic [MSHR_IDX_W-1:0]  head_ptr;
	logic [MSHR_IDX_W-1:0]  tail_ptr;
	logic                   empty;

	assign head_ptr = head_q[MSHR_IDX_W-1:0];
	assign tail_ptr = tail_q[MSHR_IDX_W-1:0];

	assign empty  = (head_q == tail_q);
	assign full_o = (head_ptr == tail_ptr) && (head_q[MSHR_IDX_W] != tail_q[MSHR_IDX_W]);

	// --------------------
	// lookups
	// --------------------

	// forward only when the matching line is the next one to fill
	always_comb begin
		lq_hit_o = 1'b0;
		lq_fwd_o = 1'b0;
		for (int i = 0; i < MSHR_NUM; i++) begin
			if (vld_q[i] && tag_q[i] == lq_tag_i && idx_q[i] == lq_idx_i) begin
				lq_hit_o = 1'b1;
				if (head_ptr == MSHR_IDX_W'(i))
					lq_fwd_o = 1'b1;
			end
		end
	end

	always_comb begin
		sq_hit_o = 1'b0;
		for (int i = 0; i < MSHR_NUM; i++) begin
			if (vld_q[i] && tag_q[i] == sq_tag_i && idx_q[i] == sq_idx_i)
				sq_hit_o = 1'b1;
		end
	end

	// --------------------
	// response side
	// --------------------

	// memory answers in order, so the head is always the entry being filled
	assign rsp_tag_o  = tag_q[head_ptr];
	assign rsp_idx_o  = idx_q[head_ptr];
	assign rsp_msg_o  = msg_q[head_ptr];
	assign rsp_slot_o = slot_q[head_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q  <= '0;
			head_q <= '0;
			tail_q <= '0;
		end else begin
			if (alloc_i) begin
				vld_q[tail_ptr] <= 1'b1;
				tail_q          <= tail_q + 1'b1;
			end
			if (ack_i) begin
				vld_q[head_ptr] <= 1'b0;
				head_q          <= head_q + 1'b1;
			end
		end
	end

	// entry fields; a retired entry goes back to zero and MSG_NONE
	always_ff @(posedge clk) begin
		if (alloc_i) begin
			tag_q[tail_ptr]  <= alloc_tag_i;
			idx_q[tail_ptr]  <= alloc_idx_i;
			msg_q[tail_ptr]  <= alloc_msg_i;
			slot_q[tail_ptr] <= alloc_slot_i;
		end
		if (ack_i) begin
			tag_q[head_ptr]  <= '0;
			idx_q[head_ptr]  <= '0;
			msg_q[head_ptr]  <= dcache_pkg::MSG_NONE;
			slot_q[head_ptr] <= '0;
		end
	end

	// --------------------
	// checks
	// --------------------
	a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
		alloc_i |-> !full_o)
		else $error("mshr_rsp allocation while full");

	// the memory side must not answer a request that was never made
	a_no_ack_empty: assert property (@(posedge clk) disable iff (rst)
		ack_i |-> !empty)
		else $error("mshr_rsp response with no pending entry");

endmodule : mshr_rsp

// ==== run_sim.sh ====
#!/bin/sh
# build and run the MSHR testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dcache_mshr -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/Vtb_dcache_mshr > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
	echo "no result line found in $LOG"
	exit 1
fi
exit 0

// ==== sim.f ====
+incdir+tb
design/dcache_pkg.sv
design/mshr_iss.sv
design/mshr_rsp.sv
design/dcache_mshr.sv
tb/tb_dcache_mshr.sv

// ==== tb/tb_cases.svh ====
// columns: test, op, tag, idx, msg, store lookup idx, then expected
// lq_hit, lq_fwd, sq_hit and full as seen in the cycle the row is applied
localparam int N_CASES = 34;

case_row_t cases [N_CASES] = '{
	// requests leave in order, at most two in flight
	'{4'd2, OP_MISS, 20'h0a001, 6'h01, dcache_pkg::MSG_READ, 6'h01, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd2, OP_MISS, 20'h0b002, 6'h02, dcache_pkg::MSG_WRITE, 6'h02, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd2, OP_MISS, 20'h0c003, 6'h03, dcache_pkg::MSG_UPGRADE, 6'h03, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd2, OP_IDLE, 20'h00000, 6'h00, dcache_pkg::MSG_NONE, 6'h00, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd2, OP_IDLE, 20'h00000, 6'h00, dcache_pkg::MSG_NONE, 6'h00, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd2, OP_RSP, 20'h0a001, 6'h01, dcache_pkg::MSG_NONE, 6'h01, 1'b1, 1'b1, 1'b1, 1'b0},
	'{4'd2, OP_RSP, 20'h0b002, 6'h02, dcache_pkg::MSG_NONE, 6'h02, 1'b1, 1'b1, 1'b1, 1'b0},
	'{4'd2, OP_RSP, 20'h0c003, 6'h03, dcache_pkg::MSG_NONE, 6'h03, 1'b1, 1'b1, 1'b1, 1'b0},
	// slots carry on from 3 and wrap to 0
	'{4'd3, OP_MISS, 20'h0d004, 6'h10, dcache_pkg::MSG_WRITE, 6'h10, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd3, OP_MISS, 20'h0e005, 6'h11, dcache_pkg::MSG_READ, 6'h11, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd3, OP_RSP, 20'h0d004, 6'h10, dcache_pkg::MSG_NONE, 6'h10, 1'b1, 1'b1, 1'b1, 1'b0},
	'{4'd3, OP_RSP, 20'h0e005, 6'h11, dcache_pkg::MSG_NONE, 6'h11, 1'b1, 1'b1, 1'b1, 1'b0},
	'{4'd3, OP_MISS, 20'h0f006, 6'h12, dcache_pkg::MSG_UPGRADE, 6'h12, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd3, OP_RSP, 20'h0f006, 6'h12, dcache_pkg::MSG_NONE, 6'h12, 1'b1, 1'b1, 1'b1, 1'b0},
	// store side uses its own index
	'{4'd4, OP_MISS, 20'h01007, 6'h20, dcache_pkg::MSG_READ, 6'h20, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd4, OP_MISS, 20'h02008, 6'h21, dcache_pkg::MSG_WRITE, 6'h21, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd4, OP_LOOK, 20'h01007, 6'h20, dcache_pkg::MSG_NONE, 6'h21, 1'b1, 1'b1, 1'b0, 1'b0},
	'{4'd4, OP_LOOK, 20'h02008, 6'h21, dcache_pkg::MSG_NONE, 6'h20, 1'b1, 1'b0, 1'b0, 1'b0},
	'{4'd4, OP_LOOK, 20'h02008, 6'h20, dcache_pkg::MSG_NONE, 6'h21, 1'b0, 1'b0, 1'b1, 1'b0},
	'{4'd4, OP_RSP, 20'h01007, 6'h20, dcache_pkg::MSG_NONE, 6'h20, 1'b1, 1'b1, 1'b1, 1'b0},
	'{4'd4, OP_LOOK, 20'h01007, 6'h20, dcache_pkg::MSG_NONE, 6'h20, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd4, OP_RSP, 20'h02008, 6'h21, dcache_pkg::MSG_NONE, 6'h21, 1'b1, 1'b1, 1'b1, 1'b0},
	// fill every entry, one extra miss is dropped
	'{4'd5, OP_MISS, 20'h0f00d, 6'h30, dcache_pkg::MSG_READ, 6'h30, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd5, OP_MISS, 20'h0f00d, 6'h31, dcache_pkg::MSG_READ, 6'h31, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd5, OP_MISS, 20'h0f00d, 6'h32, dcache_pkg::MSG_WRITE, 6'h32, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd5, OP_MISS, 20'h0f00d, 6'h33, dcache_pkg::MSG_UPGRADE, 6'h33, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd5, OP_LOOK, 20'h0f00d, 6'h30, dcache_pkg::MSG_NONE, 6'h33, 1'b1, 1'b1, 1'b1, 1'b1},
	'{4'd5, OP_MISS, 20'h0e0e0, 6'h34, dcache_pkg::MSG_READ, 6'h34, 1'b0, 1'b0, 1'b0, 1'b1},
	'{4'd5, OP_RSP, 20'h0f00d, 6'h30, dcache_pkg::MSG_NONE, 6'h30, 1'b1, 1'b1, 1'b1, 1'b1},
	'{4'd5, OP_LOOK, 20'h0e0e0, 6'h34, dcache_pkg::MSG_NONE, 6'h30, 1'b0, 1'b0, 1'b0, 1'b0},
	'{4'd5, OP_RSP, 20'h0f00d, 6'h31, dcache_pkg::MSG_NONE, 6'h31, 1'b1, 1'b1, 1'b1, 1'b0},
	'{4'd5, OP_RSP, 20'h0f00d, 6'h32, dcache_pkg::MSG_NONE, 6'h32, 1'b1, 1'b1, 1'b1, 1'b0},
	'{4'd5, OP_RSP, 20'h0f00d, 6'h33, dcache_pkg::MSG_NONE, 6'h33, 1'b1, 1'b1, 1'b1, 1'b0},
	'{4'd5, OP_LOOK, 20'h0f00d, 6'h33, dcache_pkg::MSG_NONE, 6'h30, 1'b0, 1'b0, 1'b0, 1'b0}
};

// ==== tb/tb_dcache_mshr.sv ====
module tb_dcache_mshr;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TAG_W       = dcache_pkg::DEF_TAG_W;
	localparam int IDX_W       = dcache_pkg::DEF_IDX_W;
	localparam int MSHR_NUM    = dcache_pkg::DEF_MSHR_NUM;
	localparam int MEM_CREDITS = dcache_pkg::DEF_MEM_CREDITS;
	localparam int MSHR_IDX_W  = $clog2(MSHR_NUM);

	localparam logic [1:0] OP_IDLE = 2'd0;
	localparam logic [1:0] OP_MISS = 2'd1;
	localparam logic [1:0] OP_RSP  = 2'd2;
	localparam logic [1:0] OP_LOOK = 2'd3;

	typedef struct packed {
		logic [3:0]            test;
		logic [1:0]            op;
		logic [TAG_W-1:0]      tag;
		logic [IDX_W-1:0]      idx;
		dcache_pkg::message_t  msg;
		logic [IDX_W-1:0]      sq_idx;
		logic                  lq_hit;
		logic                  lq_fwd;
		logic                  sq_hit;
		logic                  full;
	} case_row_t;

	// one accepted miss, oldest at the front
	typedef struct packed {
		logic [TAG_W-1:0]      tag;
		logic [IDX_W-1:0]      idx;
		dcache_pkg::message_t  msg;
		logic [MSHR_IDX_W-1:0] slot;
	} entry_t;

	`include "tb_cases.svh"

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    miss_i;
	logic [TAG_W-1:0]        miss_tag_i;
	logic [IDX_W-1:0]        miss_idx_i;
	dcache_pkg::message_t    miss_msg_i;
	logic                    mem_req_o;
	logic [TAG_W-1:0]        mem_req_tag_o;
	logic [IDX_W-1:0]        mem_req_idx_o;
	dcache_pkg::message_t    mem_req_msg_o;
	logic                    mem_rsp_i;
	logic                    fill_o;
	logic [TAG_W-1:0]        fill_tag_o;
	logic [IDX_W-1:0]        fill_idx_o;
	dcache_pkg::message_t    fill_msg_o;
	logic [MSHR_IDX_W-1:0]   fill_iss_slot_o;
	logic [TAG_W-1:0]        lq_tag_i;
	logic [IDX_W-1:0]        lq_idx_i;
	logic [TAG_W-1:0]        sq_tag_i;
	logic [IDX_W-1:0]        sq_idx_i;
	logic                    lq_hit_o;
	logic                    lq_fwd_o;
	logic                    sq_hit_o;
	logic                    mshr_full_o;

	entry_t                  ref_q [$];
	case_row_t               rand_rows [$];
	case_row_t               row;
	case_row_t               idle_row;
	logic [MSHR_IDX_W-1:0]   next_slot;
	int                      issued;
	int                      errors;
	int                      errors_at_start;
	int                      tests_run;
	int                      tests_failed;
	int                      cur_test;
	string                   test_names [1:6] = '{"reset state", "request order and credits",
		"fill and issue slots", "load and store lookups", "full flag", "random mix"};

	always #10 clk = ~clk;

	dcache_mshr #(
		.TAG_W       (TAG_W),
		.IDX_W       (IDX_W),
		.MSHR_NUM    (MSHR_NUM),
		.MEM_CREDITS (MEM_CREDITS)
	) dut_i (.*);

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("CHECK FAILED %s expected %h got %h", name, exp, act);
		errors++;
	endtask

	// --------------------
	// one clock cycle
	// --------------------
	task automatic run_cycle(input case_row_t r, input bit use_table);
		entry_t  e;
		logic    m_lq_hit;
		logic    m_lq_fwd;
		logic    m_sq_hit;
		logic    m_full;
		@(posedge clk);
		#2;
		miss_i     = (r.op == OP_MISS);
		miss_tag_i = r.tag;
		miss_idx_i = r.idx;
		miss_msg_i = r.msg;
		mem_rsp_i  = (r.op == OP_RSP);
		lq_tag_i   = r.tag;
		lq_idx_i   = r.idx;
		sq_tag_i   = r.tag;
		sq_idx_i   = r.sq_idx;
		#1;
		// flags follow the lines pending at the start of the cycle
		m_full   = (ref_q.size() == MSHR_NUM);
		m_lq_hit = 1'b0;
		m_lq_fwd = 1'b0;
		m_sq_hit = 1'b0;
		foreach (ref_q[i]) begin
			if (ref_q[i].tag == r.tag && ref_q[i].idx == r.idx) begin
				m_lq_hit = 1'b1;
				if (i == 0)
					m_lq_fwd = 1'b1;
			end
			if (ref_q[i].tag == r.tag && ref_q[i].idx == r.sq_idx)
				m_sq_hit = 1'b1;
		end
		if (use_table) begin
			m_lq_hit = r.lq_hit;
			m_lq_fwd = r.lq_fwd;
			m_sq_hit = r.sq_hit;
			m_full   = r.full;
		end
		if (lq_hit_o !== m_lq_hit)
			report_mismatch("lq_hit_o", 32'(m_lq_hit), 32'(lq_hit_o));
		if (lq_fwd_o !== m_lq_fwd)
			report_mismatch("lq_fwd_o", 32'(m_lq_fwd), 32'(lq_fwd_o));
		if (sq_hit_o !== m_sq_hit)
			report_mismatch("sq_hit_o", 32'(m_sq_hit), 32'(sq_hit_o));
		if (mshr_full_o !== m_full)
			report_mismatch("mshr_full_o", 32'(m_full), 32'(mshr_full_o));

		// requests go out in allocation order
		if (mem_req_o === 1'b1) begin
			if (issued >= ref_q.size()) begin
				$display("memory request seen with no pending miss left to send");
				errors++;
			end else begin
				e = ref_q[issued];
				if (mem_req_tag_o !== e.tag)
					report_mismatch("mem_req_tag_o", 32'(e.tag), 32'(mem_req_tag_o));
				if (mem_req_idx_o !== e.idx)
					report_mismatch("mem_req_idx_o", 32'(e.idx), 32'(mem_req_idx_o));
				if (mem_req_msg_o !== e.msg)
					report_mismatch("mem_req_msg_o", 32'(e.msg), 32'(mem_req_msg_o));
				issued++;
				if (issued > MEM_CREDITS) begin
					$display("more than %0d memory requests outstanding", MEM_CREDITS);
					errors++;
				end
			end
		end else if (mem_req_o !== 1'b0) begin
			report_mismatch("mem_req_o", 32'(0), 32'(mem_req_o));
		end

		// a fill is due exactly in the cycle of a response
		if (fill_o !== (r.op == OP_RSP))
			report_mismatch("fill_o", 32'(r.op == OP_RSP), 32'(fill_o));
		if (r.op == OP_RSP) begin
			e = ref_q.pop_front();
			issued--;
			if (fill_tag_o !== e.tag)
				report_mismatch("fill_tag_o", 32'(e.tag), 32'(fill_tag_o));
			if (fill_idx_o !== e.idx)
				report_mismatch("fill_idx_o", 32'(e.idx), 32'(fill_idx_o));
			if (fill_msg_o !== e.msg)
				report_mismatch("fill_msg_o", 32'(e.msg), 32'(fill_msg_o));
			if (fill_iss_slot_o !== e.slot)
				report_mismatch("fill_iss_slot_o", 32'(e.slot), 32'(fill_iss_slot_o));
		end

		// a miss while full leaves no trace
		if (r.op == OP_MISS && ref_q.size() < MSHR_NUM) begin
			ref_q.push_back('{r.tag, r.idx, r.msg, next_slot});
			next_slot++;
		end
	endtask

	// idle until a request is in flight, so a response is legal
	task automatic wait_request();
		int n;
		n = 0;
		while (issued == 0 && n < 50) begin
			run_cycle(idle_row, 1'b0);
			n++;
		end
		if (issued == 0) begin
			$display("timeout: no memory request within 50 cycles");
			$display("Result: FAILED");
			$finish;
		end
	endtask

	task automatic finish_test(input int num);
		tests_run++;
		if (errors != errors_at_start) begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", num, test_names[num],
				errors - errors_at_start);
		end else begin
			$display("test %0d %s: ok", num, test_names[num]);
		end
		errors_at_start = errors;
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		void'($urandom(32'h4bde));
		rst        = 1'b1;
		miss_i     = 1'b0;
		miss_tag_i = '0;
		miss_idx_i = '0;
		miss_msg_i = dcache_pkg::MSG_NONE;
		mem_rsp_i  = 1'b0;
		lq_tag_i   = '0;
		lq_idx_i   = '0;
		sq_tag_i   = '0;
		sq_idx_i   = '0;
		idle_row   = '0;
		next_slot  = '0;
		issued     = 0;
		errors     = 0;
		errors_at_start = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		repeat (10) run_cycle(idle_row, 1'b0);
		finish_test(1);

		cur_test = int'(cases[0].test);
		for (int i = 0; i < N_CASES; i++) begin
			if (int'(cases[i].test) != cur_test) begin
				finish_test(cur_test);
				cur_test = int'(cases[i].test);
			end
			if (cases[i].op == OP_RSP)
				wait_request();
			run_cycle(cases[i], 1'b1);
		end
		finish_test(cur_test);

		// small tag and index pools so lookups hit often
		for (int i = 0; i < 200; i++) begin
			row        = '0;
			row.test   = 4'd6;
			row.op     = 2'($urandom_range(3, 0));
			row.tag    = TAG_W'(32'h00100 + $urandom_range(3, 0));
			row.idx    = IDX_W'($urandom_range(3, 0));
			row.sq_idx = IDX_W'($urandom_range(3, 0));
			row.msg    = dcache_pkg::message_t'(2'($urandom_range(3, 1)));
			rand_rows.push_back(row);
		end
		foreach (rand_rows[i]) begin
			row = rand_rows[i];
			if (row.op == OP_RSP && issued == 0)
				row.op = OP_LOOK;
			run_cycle(row, 1'b0);
		end
		while (ref_q.size() > 0) begin
			wait_request();
			row    = idle_row;
			row.op = OP_RSP;
			run_cycle(row, 1'b0);
		end
		finish_test(6);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule : tb_dcache_mshr
